//--- build.f
rtl/emesh_pkg.sv
rtl/synchronizer.sv
rtl/memory_dp.sv
rtl/fifo_full_block.sv
rtl/fifo_empty_block.sv
rtl/fifo_async.sv
verif/tb_clkgen.sv
verif/tb_fifo_async.sv

//--- rtl/emesh_pkg.sv
package emesh_pkg;

  // ####################################################################
  // Mesh packet field widths
  // ####################################################################

  // Address field width, shared by dstaddr and srcaddr
  localparam int EMESH_AW = 32;

  // Data payload width
  localparam int EMESH_DW = 32;

  // Transfer size code
  localparam int EMESH_MODE_W = 2;

  // Control mode bits
  localparam int EMESH_CTRL_W = 4;

  // ####################################################################
  // One mesh transaction, 104 bits, msb first
  // ####################################################################

  typedef struct packed {
    // Valid traffic marker
    logic                    access;
    // Write versus read request
    logic                    write;
    // Transfer size
    logic [EMESH_MODE_W-1:0] datamode;
    logic [EMESH_CTRL_W-1:0] ctrlmode;
    // Target and return addresses around the payload
    logic [EMESH_AW-1:0]     dstaddr;
    logic [EMESH_DW-1:0]     data;
    logic [EMESH_AW-1:0]     srcaddr;
  } emesh_packet_t;

endpackage

//--- rtl/fifo_async.sv
module fifo_async
  import emesh_pkg::*;
#(
  // Address bits, depth is 2**AW
  parameter int AW = 3
) (
  input  logic          rst_n,
  input  logic          wr_clk,
  input  logic          rd_clk,
  // Producer side, wr_clk domain
  input  logic          wr_write,
  input  emesh_packet_t wr_data,
  // Consumer side, rd_clk domain
  input  logic          rd_read,
  output emesh_packet_t rd_data,
  output logic          rd_fifo_empty,
  output logic          wr_fifo_full
);

  // ####################################################################
  // Internal wiring
  // ####################################################################

  // Accepted write strobe into the array
  logic          wr_en;
  logic [AW-1:0] wr_addr;
  logic [AW-1:0] rd_addr;

  // Gray pointers, own domain
  logic [AW:0]   wr_gray_pointer;
  logic [AW:0]   rd_gray_pointer;

  // Gray pointers, after crossing
  logic [AW:0]   wr_rd_gray_pointer;
  logic [AW:0]   rd_wr_gray_pointer;

  // Packet storage, first-word fall-through read
  memory_dp #(
    .AW (AW),
    .DW ($bits(emesh_packet_t))
  ) i_memory_dp (
    .wr_clk  (wr_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Write pointer and full flag
  fifo_full_block #(
    .AW (AW)
  ) i_fifo_full_block (
    .rst_n              (rst_n),
    .wr_clk             (wr_clk),
    .wr_write           (wr_write),
    .wr_rd_gray_pointer (wr_rd_gray_pointer),
    .wr_fifo_full       (wr_fifo_full),
    .wr_en              (wr_en),
    .wr_addr            (wr_addr),
    .wr_gray_pointer    (wr_gray_pointer)
  );

  // Read pointer and empty flag
  fifo_empty_block #(
    .AW (AW)
  ) i_fifo_empty_block (
    .rst_n              (rst_n),
    .rd_clk             (rd_clk),
    .rd_read            (rd_read),
    .rd_wr_gray_pointer (rd_wr_gray_pointer),
    .rd_fifo_empty      (rd_fifo_empty),
    .rd_addr            (rd_addr),
    .rd_gray_pointer    (rd_gray_pointer)
  );

  // ####################################################################
  // Clock domain crossings
  // ####################################################################

  // Read pointer into the write domain, for full
  synchronizer #(
    .DW (AW+1)
  ) rd2wr_sync (
    .rst_n (rst_n),
    .clk   (wr_clk),
    .in    (rd_gray_pointer),
    .out   (wr_rd_gray_pointer)
  );

  // Write pointer into the read domain, for empty
  synchronizer #(
    .DW (AW+1)
  ) wr2rd_sync (
    .rst_n (rst_n),
    .clk   (rd_clk),
    .in    (wr_gray_pointer),
    .out   (rd_wr_gray_pointer)
  );

endmodule

//--- rtl/fifo_empty_block.sv
module fifo_empty_block
  import emesh_pkg::*;
#(
  // Address bits, pointers carry one extra wrap bit
  parameter int AW = 3
) (
  input  logic          rst_n,
  input  logic          rd_clk,
  input  logic          rd_read,
  // Write pointer after two read-domain flops
  input  logic [AW:0]   rd_wr_gray_pointer,
  output logic          rd_fifo_empty,
  output logic [AW-1:0] rd_addr,
  output logic [AW:0]   rd_gray_pointer
);

  logic [AW:0] rd_bin;
  logic [AW:0] rd_bin_next;
  logic [AW:0] rd_gray_next;
  logic        rd_accept;
  logic        empty_next;

  // ####################################################################
  // Accept and next pointer
  // ####################################################################

  // Reads while empty are dropped
  assign rd_accept = rd_read & ~rd_fifo_empty;

  assign rd_bin_next  = rd_bin + {{AW{1'b0}}, rd_accept};
  // Binary to Gray
  assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

  // Empty when the read side has caught up with the write side
  assign empty_next = (rd_gray_next == rd_wr_gray_pointer);

  // ####################################################################
  // Pointer and flag registers
  // ####################################################################

  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      rd_bin          <= '0;
      rd_gray_pointer <= '0;
      // Nothing stored out of reset
      rd_fifo_empty   <= 1'b1;
    end else begin
      rd_bin          <= rd_bin_next;
      rd_gray_pointer <= rd_gray_next;
      // Updated with the pointer, so the last read shows empty at once
      rd_fifo_empty   <= empty_next;
    end
  end

  // Lower bits select the head packet
  assign rd_addr = rd_bin[AW-1:0];

  // Gray pointer crosses domains, one bit per step at most
  property p_rd_gray_step;
    @(posedge rd_clk) disable iff (!rst_n)
      $countones(rd_gray_pointer ^ $past(rd_gray_pointer)) <= 1;
  endproperty
  a_rd_gray_step : assert property (p_rd_gray_step)
    else $error("fifo_empty_block: read Gray pointer moved more than one bit");

  // Head stays put while nothing is stored
  property p_rd_hold_when_empty;
    @(posedge rd_clk) disable iff (!rst_n)
      rd_fifo_empty |=> $stable(rd_addr);
  endproperty
  a_rd_hold_when_empty : assert property (p_rd_hold_when_empty)
    else $error("fifo_empty_block: read address moved while empty");

endmodule

//--- rtl/fifo_full_block.sv
module fifo_full_block
  import emesh_pkg::*;
#(
  // Address bits, pointers carry one extra wrap bit
  parameter int AW = 3
) (
  input  logic          rst_n,
  input  logic          wr_clk,
  input  logic          wr_write,
  // Read pointer after two write-domain flops
  input  logic [AW:0]   wr_rd_gray_pointer,
  output logic          wr_fifo_full,
  output logic          wr_en,
  output logic [AW-1:0] wr_addr,
  output logic [AW:0]   wr_gray_pointer
);

  // Top two bits set, flips the read pointer into the full pattern
  localparam logic [AW:0] TOP_MASK = (AW+1)'(3) << (AW-1);

  logic [AW:0] wr_bin;
  logic [AW:0] wr_bin_next;
  logic [AW:0] wr_gray_next;
  logic        full_next;

  // ####################################################################
  // Accept and next pointer
  // ####################################################################

  // Writes while full are dropped
  assign wr_en = wr_write & ~wr_fifo_full;

  assign wr_bin_next  = wr_bin + {{AW{1'b0}}, wr_en};
  // Binary to Gray
  assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

  // Full when the write side is one lap ahead of the read side
  assign full_next = (wr_gray_next == (wr_rd_gray_pointer ^ TOP_MASK));

  // ####################################################################
  // Pointer and flag registers
  // ####################################################################

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      wr_bin          <= '0;
      wr_gray_pointer <= '0;
      wr_fifo_full    <= 1'b0;
    end else begin
      wr_bin          <= wr_bin_next;
      wr_gray_pointer <= wr_gray_next;
      // Same edge as the pointer move, never a cycle late
      wr_fifo_full    <= full_next;
    end
  end

  // Lower bits index the memory
  assign wr_addr = wr_bin[AW-1:0];

  // Gray pointer crosses domains, one bit per step at most
  property p_wr_gray_step;
    @(posedge wr_clk) disable iff (!rst_n)
      $countones(wr_gray_pointer ^ $past(wr_gray_pointer)) <= 1;
  endproperty
  a_wr_gray_step : assert property (p_wr_gray_step)
    else $error("fifo_full_block: write Gray pointer moved more than one bit");

  // No slot is claimed while full
  property p_wr_hold_when_full;
    @(posedge wr_clk) disable iff (!rst_n)
      wr_fifo_full |=> $stable(wr_addr);
  endproperty
  a_wr_hold_when_full : assert property (p_wr_hold_when_full)
    else $error("fifo_full_block: write address moved while full");

endmodule

//--- rtl/memory_dp.sv
module memory_dp
  import emesh_pkg::*;
#(
  // Address bits, depth is 2**AW
  parameter int AW = 3,
  // Stored word width
  parameter int DW = $bits(emesh_packet_t)
) (
  input  logic          wr_clk,
  input  logic          wr_en,
  input  logic [AW-1:0] wr_addr,
  input  emesh_packet_t wr_data,
  input  logic [AW-1:0] rd_addr,
  output emesh_packet_t rd_data
);

  localparam int DEPTH = 1 << AW;

  // Word width must hold exactly one packet
  if (DW != $bits(emesh_packet_t)) begin : g_dw_check
    $error("memory_dp: DW %0d does not match packet width %0d",
           DW, $bits(emesh_packet_t));
  end

  // ####################################################################
  // Storage array
  // ####################################################################

  logic [DW-1:0] mem [DEPTH];

  // Write port, word stored at the accepting edge
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, no clock
  // Head packet visible as soon as rd_addr points at it
  assign rd_data = mem[rd_addr];

endmodule

//--- rtl/synchronizer.sv
module synchronizer #(
  // Bus width, Gray-coded buses only
  parameter int DW = 4
) (
  input  logic          rst_n,
  input  logic          clk,
  input  logic [DW-1:0] in,
  output logic [DW-1:0] out
);

  // First stage, may go metastable
  logic [DW-1:0] sync_q0;

  // Two flops in series on the destination clock
  // Output settles exactly two edges after an input change
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q0 <= '0;
      out     <= '0;
    end else begin
      sync_q0 <= in;
      // Second stage resolves the first
      out     <= sync_q0;
    end
  end

endmodule

//--- verif/tb_clkgen.sv
module tb_clkgen #(
  // Half of the clock period, in time units
  parameter int HALF_PERIOD = 5
) (
  output logic clk
);

  // Starts low, first rising edge after one half period
  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD);
      clk = ~clk;
    end
  end

endmodule

//--- verif/tb_fifo_async.sv
module tb_fifo_async
  import emesh_pkg::*;
;

  // ####################################################################
  // Test constants
  // ####################################################################

  localparam int AW          = 3;
  localparam int DEPTH       = 1 << AW;
  localparam int WR_PERIOD   = 10;
  localparam int RD_PERIOD   = 14;
  localparam int RAND_CYCLES = 600;
  // Read cycles spanning the same time as the write cycles
  localparam int RD_CYCLES   = RAND_CYCLES * WR_PERIOD / RD_PERIOD;
  // Fill, drain, empty protection and random traffic
  localparam int TXN_COUNT   = 2 * DEPTH + 4 + RAND_CYCLES;
  localparam int TIME_LIMIT  = TXN_COUNT * 20 * RD_PERIOD + 8 * WR_PERIOD;

  logic          wr_clk;
  logic          rd_clk;
  logic          rst_n;
  logic          wr_write;
  emesh_packet_t wr_data;
  logic          rd_read;
  emesh_packet_t rd_data;
  logic          rd_fifo_empty;
  logic          wr_fifo_full;

  // Reference model and bookkeeping
  emesh_packet_t model [$];
  int            wr_count;
  int            rd_count;
  time           last_write_time;
  logic          idle_check_en;
  string         test_name;
  logic [31:0]   lfsr_state;

  // Precomputed random traffic
  logic          wr_en_plan [RAND_CYCLES];
  emesh_packet_t pkt_plan   [RAND_CYCLES];
  logic          rd_en_plan [RD_CYCLES];

  // Two unrelated clocks so the pointers drift across the crossing
  tb_clkgen #(.HALF_PERIOD(WR_PERIOD / 2)) i_wr_clkgen (.clk(wr_clk));
  tb_clkgen #(.HALF_PERIOD(RD_PERIOD / 2)) i_rd_clkgen (.clk(rd_clk));

  fifo_async #(
    .AW (AW)
  ) i_dut (
    .rst_n         (rst_n),
    .wr_clk        (wr_clk),
    .rd_clk        (rd_clk),
    .wr_write      (wr_write),
    .wr_data       (wr_data),
    .rd_read       (rd_read),
    .rd_data       (rd_data),
    .rd_fifo_empty (rd_fifo_empty),
    .wr_fifo_full  (wr_fifo_full)
  );

  // ####################################################################
  // Random source
  // ####################################################################

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One step per bit drawn
  function automatic logic take_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  function automatic emesh_packet_t random_packet();
    emesh_packet_t p;
    p.access   = 1'b1;
    p.write    = take_bit();
    p.datamode = EMESH_MODE_W'(take_bits(EMESH_MODE_W));
    p.ctrlmode = EMESH_CTRL_W'(take_bits(EMESH_CTRL_W));
    p.dstaddr  = take_bits(EMESH_AW);
    p.data     = take_bits(EMESH_DW);
    p.srcaddr  = take_bits(EMESH_AW);
    return p;
  endfunction

  // Level 0..2 gives a probability of 1/4, 1/2 or 3/4
  function automatic logic draw_enable(input int level);
    return take_bits(2) <= level;
  endfunction

  // ####################################################################
  // Compare tasks
  // ####################################################################

  task automatic check_packet(input string name, input emesh_packet_t expected,
                              input emesh_packet_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "packet mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %b, actual %b", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic verify_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  // ####################################################################
  // Model update at the ports
  // ####################################################################

  // Accepted write pushes the packet
  always @(posedge wr_clk) begin
    if (rst_n && wr_write && !wr_fifo_full) begin
      model.push_back(wr_data);
      wr_count        = wr_count + 1;
      last_write_time = $time;
    end
  end

  // Accepted read pops and compares the head
  always @(posedge rd_clk) begin
    // Idle and settled means empty
    if (idle_check_en && wr_count == rd_count &&
        ($time - last_write_time) > 4 * RD_PERIOD) begin
      check_flag("idle_empty", 1'b1, rd_fifo_empty);
    end
    if (rst_n && rd_read && !rd_fifo_empty) begin
      if (model.size() == 0) begin
        fail_now("A read was accepted while the model held no packet");
      end else begin
        check_packet(test_name, model.pop_front(), rd_data);
        rd_count = rd_count + 1;
      end
    end
  end

  // Hard limit on the run length
  initial begin
    #(TIME_LIMIT);
    $display("The run did not finish within %0d time units", TIME_LIMIT);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

  // Read everything back, then wait for the flag to settle
  task automatic drain_all(input string name);
    @(posedge rd_clk);
    rd_read <= 1'b1;
    wait (rd_count == wr_count);
    @(posedge rd_clk);
    rd_read <= 1'b0;
    repeat (4) @(posedge rd_clk);
    check_flag({name, "_empty"}, 1'b1, rd_fifo_empty);
    repeat (4) @(posedge wr_clk);
    check_flag({name, "_not_full"}, 1'b0, wr_fifo_full);
  endtask

  // ####################################################################
  // Test sequence
  // ####################################################################

  initial begin
    emesh_packet_t pkt;
    logic          full_seen;
    int            base;

    rst_n           = 1'b0;
    wr_write        = 1'b0;
    wr_data         = '0;
    rd_read         = 1'b0;
    wr_count        = 0;
    rd_count        = 0;
    last_write_time = 0;
    idle_check_en   = 1'b0;
    test_name       = "reset";
    lfsr_state      = 32'd59;

    repeat (8) @(posedge wr_clk);
    rst_n <= 1'b1;

    // Reset state
    repeat (2) @(posedge rd_clk);
    check_flag("reset_empty", 1'b1, rd_fifo_empty);
    @(posedge wr_clk);
    check_flag("reset_full", 1'b0, wr_fifo_full);

    // Fill until full, new packet only after an accepted write
    test_name = "fill";
    base      = wr_count;
    full_seen = 1'b0;
    @(posedge wr_clk);
    wr_write <= 1'b1;
    wr_data  <= random_packet();
    while (!full_seen) begin
      @(posedge wr_clk);
      if (wr_fifo_full) begin
        full_seen = 1'b1;
      end else begin
        wr_data <= random_packet();
      end
    end
    verify_count("fill_accepted", DEPTH, wr_count - base);
    // Writes held against full
    repeat (4) @(posedge wr_clk);
    wr_write <= 1'b0;
    check_flag("fill_stays_full", 1'b1, wr_fifo_full);
    verify_count("fill_model_size", DEPTH, model.size());

    // Drain in order
    test_name = "drain";
    drain_all("drain");

    // Reads pulsed against empty
    test_name = "empty_protect";
    @(posedge rd_clk);
    rd_read <= 1'b1;
    repeat (3) begin
      @(posedge rd_clk);
      check_flag("empty_protect_flag", 1'b1, rd_fifo_empty);
    end
    rd_read <= 1'b0;
    pkt = random_packet();
    @(posedge wr_clk);
    wr_write <= 1'b1;
    wr_data  <= pkt;
    @(posedge wr_clk);
    wr_write <= 1'b0;
    // Head shows up once empty falls
    @(posedge rd_clk);
    while (rd_fifo_empty) begin
      @(posedge rd_clk);
    end
    check_packet("empty_protect_first", pkt, rd_data);
    rd_read <= 1'b1;
    @(posedge rd_clk);
    rd_read <= 1'b0;
    wait (rd_count == wr_count);

    // Random traffic, fill heavy, then balanced, then drain heavy
    for (int i = 0; i < RAND_CYCLES; i++) begin
      wr_en_plan[i] = draw_enable(2 - (i * 3 / RAND_CYCLES));
      pkt_plan[i]   = random_packet();
    end
    for (int j = 0; j < RD_CYCLES; j++) begin
      rd_en_plan[j] = draw_enable(j * 3 / RD_CYCLES);
    end
    test_name     = "random";
    idle_check_en = 1'b1;
    fork
      begin
        for (int i = 0; i < RAND_CYCLES; i++) begin
          @(posedge wr_clk);
          wr_write <= wr_en_plan[i];
          wr_data  <= pkt_plan[i];
        end
        @(posedge wr_clk);
        wr_write <= 1'b0;
      end
      begin
        for (int j = 0; j < RD_CYCLES; j++) begin
          @(posedge rd_clk);
          rd_read <= rd_en_plan[j];
        end
      end
    join
    // Leftover packets still checked against the model
    drain_all("random");
    idle_check_en = 1'b0;

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
